/* verif/execute_stimulus.txt */
# kind pc npc imm rdata1 rdata2 waddr flags(wren rden2 lui auipc jal jalr branch load store div)
# alu bcu lsu div | wren wdata jump target address byteenable exception ecause (kind 1 = flush)
0 100 104 0 5 7 1 1100000000 0 0 0 0 1 c 0 104 5 0 0 0
0 104 108 0 5 7 2 1100000000 1 0 0 0 1 fffffffe 0 108 5 0 0 0
0 108 10c fffffff0 20 0 3 1000000000 0 0 0 0 1 10 0 10c 10 0 0 0
0 10c 110 0 1 23 4 1100000000 2 0 0 0 1 8 0 110 1 0 0 0
0 110 114 0 ffffffff 1 5 1100000000 3 0 0 0 1 1 0 114 ffffffff 0 0 0
0 114 118 0 ffffffff 1 6 1100000000 4 0 0 0 1 0 0 118 ffffffff 0 0 0
0 118 11c ff f0f 0 7 1000000000 5 0 0 0 1 ff0 0 11c 100e 0 0 0
0 11c 120 0 80000000 4 8 1100000000 6 0 0 0 1 8000000 0 120 80000000 0 0 0
0 120 124 0 80000000 4 9 1100000000 7 0 0 0 1 f8000000 0 124 80000000 0 0 0
0 124 128 f f0 0 a 1000000000 8 0 0 0 1 ff 0 128 ff 0 0 0
0 128 12c 0 ff00 ff0 b 1100000000 9 0 0 0 1 f00 0 12c ff00 0 0 0
0 12c 130 12345000 0 0 c 1010000000 0 0 0 0 1 12345000 0 130 12345000 0 0 0
0 130 134 1000 0 0 d 1001000000 0 0 0 0 1 1130 0 134 1130 0 0 0
0 134 138 10 3 3 0 0000001000 0 0 0 0 0 13 1 144 144 0 0 0
0 138 13c 10 3 3 0 0000001000 0 1 0 0 0 13 0 148 148 0 0 0
0 13c 140 fffffff8 ffffffff 1 0 0000001000 0 4 0 0 0 fffffff7 1 134 134 0 0 0
0 140 144 20 ffffffff 1 0 0000001000 0 7 0 0 0 1f 1 160 160 0 0 0
0 144 148 20 ffffffff 1 0 0000001000 0 6 0 0 0 1f 0 164 164 0 0 0
0 148 14c 8 ffffffff 1 0 0000001000 0 5 0 0 0 7 0 150 150 0 0 0
0 14c 150 100 0 0 1 1000100000 0 0 0 0 1 150 1 24c 24c 0 0 0
0 150 154 5 200 0 1 1000010000 0 0 0 0 1 154 1 204 204 0 0 0
0 154 158 2 0 0 1 1000100000 0 0 0 0 0 158 0 156 156 0 1 0
0 158 15c 4 1000 0 e 1000000100 0 0 2 0 1 1004 0 15c 1004 f 0 0
0 15c 160 2 1000 0 e 1000000100 0 0 1 0 1 1002 0 160 1002 c 0 0
0 160 164 3 1000 0 e 1000000100 0 0 4 0 1 1003 0 164 1003 8 0 0
0 164 168 8 2000 deadbeef 0 0000000010 0 0 2 0 0 2008 0 168 2008 f 0 0
0 168 16c 1 2000 55 0 0000000010 0 0 0 0 0 2001 0 16c 2001 2 0 0
0 16c 170 2 1000 0 e 1000000100 0 0 2 0 0 1002 0 170 1002 f 1 4
0 170 174 1 2000 1234 0 0000000010 0 0 1 0 0 2001 0 174 2001 3 1 6
0 174 178 0 ffffffec 3 f 1100000001 0 0 0 0 1 fffffffa 0 178 ffffffec 0 0 0
0 178 17c 0 ffffffec 3 f 1100000001 0 0 0 2 1 fffffffe 0 17c ffffffec 0 0 0
0 17c 180 0 64 7 f 1100000001 0 0 0 1 1 e 0 180 64 0 0 0
0 180 184 0 1234 0 f 1100000001 0 0 0 3 1 1234 0 184 1234 0 0 0
0 184 188 0 1234 0 f 1100000001 0 0 0 0 1 ffffffff 0 188 1234 0 0 0
0 188 18c 0 80000000 ffffffff f 1100000001 0 0 0 0 1 80000000 0 18c 80000000 0 0 0
0 18c 190 0 80000000 ffffffff f 1100000001 0 0 0 2 1 0 0 190 80000000 0 0 0
1 190 194 0 64 7 f 1100000001 0 0 0 1 0 0 0 0 0 0 0 0
1 194 198 0 1 2 3 1100000000 0 0 0 0 0 0 0 0 0 0 0 0
0 198 19c 0 1 2 3 1100000000 0 0 0 0 1 3 0 19c 1 0 0 0

/* sim.f */
hdl/execute_pkg.sv
hdl/alu.sv
hdl/branch_unit.sv
hdl/address_unit.sv
hdl/serial_divider.sv
hdl/execute_stage.sv
hdl/execute_top.sv
verif/execute_tb.sv

/* Bender.yml */
package:
  name: execute_stage

sources:
  - hdl/execute_pkg.sv
  - hdl/alu.sv
  - hdl/branch_unit.sv
  - hdl/address_unit.sv
  - hdl/serial_divider.sv
  - hdl/execute_stage.sv
  - hdl/execute_top.sv
  - target: simulation
    files:
      - verif/execute_tb.sv

/* verif/execute_tb.sv */
module execute_tb;
    timeunit 1ns;
    timeprecision 100ps;

    import execute_pkg::*;

    localparam int XLEN = xlen;

    logic clock;
    logic reset;
    logic mem_stall;
    logic flush;
    logic stall;
    execute_in_type execute_in;
    execute_out_type execute_out;
    string lines[$];
    int num_lines = 0;
    int errors = 0;
    integer seed = 32'hd894;

    execute_top #(.XLEN(XLEN)) UUT (
        .clock(clock),
        .reset(reset),
        .execute_in(execute_in),
        .mem_stall(mem_stall),
        .flush(flush),
        .execute_out(execute_out),
        .stall(stall)
    );

    initial begin
        clock = 1'b0;
        forever #4 clock = ~clock;
    end

    task automatic check_field(input string name, input logic [XLEN-1:0] expected,
                               input logic [XLEN-1:0] actual);
        assert (actual === expected) else begin
            errors++;
            $display("Error: time %0t %s expected %h actual %h", $time, name, expected, actual);
            $display("test failed");
            $fatal(1);
        end
    endtask

    task automatic run_line(input string line);
        int kind;
        int count;
        int n;
        int gaps;
        logic [31:0] pc, npc, imm, r1, r2, waddr, alu, bcu, lsu, dv;
        logic [31:0] e_wren, e_wdata, e_jump, e_target, e_addr, e_be, e_exc, e_cause;
        logic [9:0] flags;
        execute_in_type instr;
        execute_out_type held;
        if ($sscanf(line, "%d %h %h %h %h %h %h %b %h %h %h %h %h %h %h %h %h %h %h %h",
                    kind, pc, npc, imm, r1, r2, waddr, flags, alu, bcu, lsu, dv,
                    e_wren, e_wdata, e_jump, e_target, e_addr, e_be, e_exc, e_cause) != 20) begin
            $display("A stimulus line could not be parsed: %s", line);
            $display("test failed");
            $fatal(1);
        end
        instr = '0;
        instr.valid = 1'b1;
        instr.pc = pc;
        instr.npc = npc;
        instr.imm = imm;
        instr.rdata1 = r1;
        instr.rdata2 = r2;
        instr.waddr = waddr[4:0];
        {instr.wren, instr.rden2, instr.lui, instr.auipc, instr.jal, instr.jalr,
         instr.branch, instr.load, instr.store, instr.division} = flags;
        instr.alu_op = alu_op_type'(alu[3:0]);
        instr.bcu_op = bcu_op_type'(bcu[2:0]);
        instr.lsu_op = lsu_op_type'(lsu[2:0]);
        instr.div_op = div_op_type'(dv[1:0]);

        if (kind == 1) begin
            // Flush lands while the instruction is still in the stage.
            @(posedge clock);
            execute_in <= instr;
            flush <= !instr.division;
            if (instr.division) begin
                repeat (3) begin
                    @(negedge clock);
                    check_field("stall", 1, stall);
                end
                @(posedge clock);
                flush <= 1'b1;
            end
            @(posedge clock);
            flush <= 1'b0;
            execute_in.valid <= 1'b0;
            @(negedge clock);
            check_field("execute_out.valid", 0, execute_out.valid);
            check_field("execute_out.wren", 0, execute_out.wren);
            check_field("execute_out.load", 0, execute_out.load);
            check_field("execute_out.store", 0, execute_out.store);
            check_field("execute_out.jump", 0, execute_out.jump);
            check_field("execute_out.exception", 0, execute_out.exception);
            check_field("stall", 0, stall);
        end else begin
            n = (($random(seed) & 3) == 0) ? 1 + (($random(seed) & 32'h7fff) % 3) : 0;
            @(posedge clock);
            execute_in <= instr;
            mem_stall <= (n > 0);
            @(negedge clock);
            held = execute_out;
            for (int i = 0; i < n; i++) begin
                check_field("stall", 1, stall);
                @(posedge clock);
                if (i == n - 1) mem_stall <= 1'b0;
                @(negedge clock);
                check_field("execute_out held", 1, execute_out === held);
            end
            count = 0;
            while (stall) begin
                count++;
                if (count > 1) check_field("execute_out.valid", 0, execute_out.valid);
                @(negedge clock);
            end
            // The cycle before the divider starts is counted as well.
            check_field("stall cycles", instr.division ? XLEN + 2 : 0, count);
            @(posedge clock);
            execute_in.valid <= 1'b0;
            @(negedge clock);
            check_field("execute_out.valid", 1, execute_out.valid);
            check_field("execute_out.pc", pc, execute_out.pc);
            check_field("execute_out.waddr", waddr[4:0], execute_out.waddr);
            check_field("execute_out.wren", e_wren, execute_out.wren);
            check_field("execute_out.wdata", e_wdata, execute_out.wdata);
            check_field("execute_out.jump", e_jump, execute_out.jump);
            check_field("execute_out.target", e_target, execute_out.target);
            check_field("execute_out.address", e_addr, execute_out.address);
            check_field("execute_out.byteenable", e_be, execute_out.byteenable);
            check_field("execute_out.exception", e_exc, execute_out.exception);
            check_field("execute_out.ecause", e_cause, execute_out.ecause);
            check_field("execute_out.load", instr.load & ~e_exc[0], execute_out.load);
            check_field("execute_out.store", instr.store & ~e_exc[0], execute_out.store);
            check_field("execute_out.lsu_op", lsu[2:0], execute_out.lsu_op);
            check_field("execute_out.sdata", r2, execute_out.sdata);
            if (e_exc[0]) check_field("execute_out.etval", e_addr, execute_out.etval);
        end
        gaps = ($random(seed) & 32'h7fff) % 3; // Idle cycles between instructions.
        repeat (gaps) @(posedge clock);
    endtask

    //////////////////////
    // Main sequence
    //////////////////////

    initial begin
        int fd;
        string line;
        execute_in = '0;
        mem_stall = 1'b0;
        flush = 1'b0;
        reset = 1'b0;
        fd = $fopen("verif/execute_stimulus.txt", "r");
        if (fd == 0) begin
            $display("The stimulus file could not be opened.");
            $display("test failed");
            $fatal(1);
        end
        while (!$feof(fd)) begin
            if ($fgets(line, fd) > 0 && line.len() > 4 && line[0] != "#") lines.push_back(line);
        end
        $fclose(fd);
        num_lines = lines.size();
        repeat (5) @(posedge clock);
        reset <= 1'b1;
        @(negedge clock);
        check_field("execute_out after reset", 1, execute_out === init_execute_out);
        check_field("stall", 0, stall);
        foreach (lines[i]) run_line(lines[i]);
        repeat (2) @(posedge clock);
        if (errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

    initial begin
        wait (num_lines > 0);
        #(num_lines * (XLEN + 12) * 8);
        $display("The run did not finish within the watchdog time.");
        $display("test failed");
        $fatal(1);
    end

endmodule

/* hdl/execute_top.sv */
module execute_top #(
    parameter int XLEN = execute_pkg::xlen
) (
    input logic clock,
    input logic reset,
    input execute_pkg::execute_in_type execute_in,
    input logic mem_stall,
    input logic flush,
    output execute_pkg::execute_out_type execute_out,
    output logic stall
);
    import execute_pkg::*;

    alu_op_type alu_op;
    logic [XLEN-1:0] alu_a;
    logic [XLEN-1:0] alu_b;
    logic [XLEN-1:0] alu_result;
    bcu_op_type bcu_op;
    logic bcu_taken;
    execute_in_type address_in;
    logic [XLEN-1:0] address;
    logic [XLEN-1:0] target;
    logic [3:0] byteenable;
    logic misaligned;
    ecause_type ecause;
    logic [XLEN-1:0] etval;
    div_op_type div_op;
    logic div_start;
    logic [XLEN-1:0] div_result;
    logic div_ready;

    execute_stage #(.XLEN(XLEN)) execute_stage_comp (
        .clock(clock),
        .reset(reset),
        .execute_in(execute_in),
        .mem_stall(mem_stall),
        .flush(flush),
        .execute_out(execute_out),
        .stall(stall),
        .alu_op(alu_op),
        .alu_a(alu_a),
        .alu_b(alu_b),
        .alu_result(alu_result),
        .bcu_op(bcu_op),
        .bcu_taken(bcu_taken),
        .address_in(address_in),
        .address(address),
        .byteenable(byteenable),
        .target(target),
        .misaligned(misaligned),
        .ecause(ecause),
        .etval(etval),
        .div_op(div_op),
        .div_start(div_start),
        .div_result(div_result),
        .div_ready(div_ready)
    );

    alu #(.XLEN(XLEN)) alu_comp (
        .alu_op(alu_op),
        .alu_a(alu_a),
        .alu_b(alu_b),
        .alu_result(alu_result)
    );

    // Branch and divide operands come from the register values the stage forwards.
    branch_unit #(.XLEN(XLEN)) branch_unit_comp (
        .bcu_op(bcu_op),
        .rdata1(address_in.rdata1),
        .rdata2(address_in.rdata2),
        .enable(address_in.branch),
        .taken(bcu_taken)
    );

    address_unit #(.XLEN(XLEN)) address_unit_comp (
        .address_in(address_in),
        .address(address),
        .target(target),
        .byteenable(byteenable),
        .misaligned(misaligned),
        .ecause(ecause),
        .etval(etval)
    );

    serial_divider #(.XLEN(XLEN)) serial_divider_comp (
        .clock(clock),
        .reset(reset),
        .start(div_start),
        .div_op(div_op),
        .dividend(address_in.rdata1),
        .divisor(address_in.rdata2),
        .result(div_result),
        .ready(div_ready)
    );

endmodule

/* hdl/execute_stage.sv */
module execute_stage #(
    parameter int XLEN = execute_pkg::xlen
) (
    input logic clock,
    input logic reset,
    input execute_pkg::execute_in_type execute_in,
    input logic mem_stall,
    input logic flush,
    output execute_pkg::execute_out_type execute_out,
    output logic stall,
    output execute_pkg::alu_op_type alu_op,
    output logic [XLEN-1:0] alu_a,
    output logic [XLEN-1:0] alu_b,
    input logic [XLEN-1:0] alu_result,
    output execute_pkg::bcu_op_type bcu_op,
    input logic bcu_taken,
    output execute_pkg::execute_in_type address_in,
    input logic [XLEN-1:0] address,
    input logic [3:0] byteenable,
    input logic [XLEN-1:0] target,
    input logic misaligned,
    input execute_pkg::ecause_type ecause,
    input logic [XLEN-1:0] etval,
    output execute_pkg::div_op_type div_op,
    output logic div_start,
    input logic [XLEN-1:0] div_result,
    input logic div_ready
);
    import execute_pkg::*;

    execute_out_type v;
    logic div_busy;
    logic div_done;
    logic div_wait;

    //////////////////////
    // Operand steering
    //////////////////////

    always_comb begin
        alu_op = execute_in.alu_op;
        alu_a = execute_in.rdata1;
        alu_b = execute_in.rden2 ? execute_in.rdata2 : execute_in.imm;
        bcu_op = execute_in.bcu_op;
        div_op = execute_in.div_op;

        address_in = execute_in;
        address_in.load = execute_in.valid & execute_in.load;
        address_in.store = execute_in.valid & execute_in.store;
        address_in.jal = execute_in.valid & execute_in.jal;
        address_in.jalr = execute_in.valid & execute_in.jalr;
        address_in.branch = execute_in.valid & execute_in.branch;

        // The divider result counts once ready has been seen for this instruction.
        div_wait = execute_in.valid & execute_in.division & ~((div_busy & div_ready) | div_done);
        div_start = execute_in.valid & execute_in.division & ~div_busy & ~div_done
                    & ~mem_stall & ~flush;
        stall = mem_stall | div_wait;
    end

    //////////////////////
    // Result selection
    //////////////////////

    always_comb begin
        v = init_execute_out;
        v.valid = execute_in.valid;
        v.pc = execute_in.pc;
        v.wren = execute_in.wren;
        v.waddr = execute_in.waddr;
        v.load = execute_in.load;
        v.store = execute_in.store;
        v.lsu_op = execute_in.lsu_op;
        v.address = address;
        v.byteenable = byteenable;
        v.sdata = execute_in.rdata2;
        v.target = target;
        v.jump = execute_in.jal | execute_in.jalr | bcu_taken;

        if (execute_in.auipc) begin
            v.wdata = address;
        end else if (execute_in.lui) begin
            v.wdata = execute_in.imm;
        end else if (execute_in.jal | execute_in.jalr) begin
            v.wdata = execute_in.npc; // Link address.
        end else if (execute_in.division) begin
            v.wdata = div_result;
        end else begin
            v.wdata = alu_result;
        end

        // A branch that is not taken cannot fault on its target.
        if (misaligned & (v.load | v.store | v.jump)) begin
            v.exception = 1'b1;
            v.ecause = ecause;
            v.etval = etval;
            v.load = 1'b0;
            v.store = 1'b0;
            v.jump = 1'b0;
            v.wren = 1'b0;
        end

        if (~execute_in.valid | div_wait) begin
            v.valid = 1'b0;
            v.wren = 1'b0;
            v.load = 1'b0;
            v.store = 1'b0;
            v.jump = 1'b0;
            v.exception = 1'b0;
        end
    end

    //////////////////////
    // State
    //////////////////////

    always_ff @(posedge clock) begin
        if (reset == 0) begin
            div_busy <= 1'b0;
            div_done <= 1'b0;
        end else if (flush) begin
            div_busy <= 1'b0; // Abandon the divide in flight.
            div_done <= 1'b0;
        end else if (div_start) begin
            div_busy <= 1'b1;
        end else if (~mem_stall & ~div_wait) begin
            div_busy <= 1'b0;
            div_done <= 1'b0;
        end else if (div_busy & div_ready) begin
            div_done <= 1'b1; // Memory stage is holding us, keep the result.
        end
    end

    always_ff @(posedge clock) begin
        if (reset == 0) begin
            execute_out <= init_execute_out;
        end else if (flush) begin
            execute_out <= init_execute_out;
        end else if (~mem_stall) begin
            execute_out <= v;
        end
    end

    // A divide in flight is only restarted after ready or a flush.
    assert property (@(posedge clock) disable iff (reset == 0)
        div_busy && !div_ready && !div_done && !flush |=> !div_start);

    assert property (@(posedge clock) disable iff (reset == 0)
        mem_stall && !flush |=> $stable(execute_out));

endmodule

/* hdl/serial_divider.sv */
module serial_divider #(
    parameter int XLEN = execute_pkg::xlen
) (
    input logic clock,
    input logic reset,
    input logic start,
    input execute_pkg::div_op_type div_op,
    input logic [XLEN-1:0] dividend,
    input logic [XLEN-1:0] divisor,
    output logic [XLEN-1:0] result,
    output logic ready
);
    import execute_pkg::*;

    localparam int cw = $clog2(XLEN + 1);

    logic [cw-1:0] count;
    logic running;
    logic [XLEN-1:0] quotient;
    logic [XLEN-1:0] remainder;
    logic [XLEN-1:0] magnitude;
    logic neg_q;
    logic neg_r;
    logic want_rem;
    logic a_neg;
    logic b_neg;
    logic [XLEN:0] shifted;
    logic [XLEN+1:0] diff;

    always_comb begin
        a_neg = (div_op == div_div || div_op == div_rem) & dividend[XLEN-1];
        b_neg = (div_op == div_div || div_op == div_rem) & divisor[XLEN-1];
        shifted = {remainder, quotient[XLEN-1]};
        diff = {1'b0, shifted} - {2'b00, magnitude}; // Top bit set means the step fails.
    end

    always_ff @(posedge clock) begin
        if (reset == 0) begin
            running <= 1'b0;
            ready <= 1'b0;
            count <= '0;
        end else begin
            ready <= 1'b0;
            if (start) begin
                running <= 1'b1;
                count <= cw'(XLEN);
            end else if (running) begin
                if (count != 0) begin
                    count <= count - 1'b1;
                end else begin
                    running <= 1'b0; // Sign fix cycle.
                    ready <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clock) begin
        if (start) begin
            quotient <= a_neg ? -dividend : dividend;
            remainder <= '0;
            magnitude <= b_neg ? -divisor : divisor;
            neg_q <= (a_neg ^ b_neg) & (divisor != '0); // Divide by zero keeps all ones.
            neg_r <= a_neg;
            want_rem <= (div_op == div_rem) || (div_op == div_remu);
        end else if (running && count != 0) begin
            if (diff[XLEN+1]) begin
                remainder <= shifted[XLEN-1:0];
                quotient <= {quotient[XLEN-2:0], 1'b0};
            end else begin
                remainder <= diff[XLEN-1:0];
                quotient <= {quotient[XLEN-2:0], 1'b1};
            end
        end else if (running) begin
            result <= want_rem ? (neg_r ? -remainder : remainder)
                               : (neg_q ? -quotient : quotient);
        end
    end

    assert property (@(posedge clock) disable iff (reset == 0) ready |=> !ready);

endmodule

/* hdl/address_unit.sv */
module address_unit #(
    parameter int XLEN = execute_pkg::xlen
) (
    input execute_pkg::execute_in_type address_in,
    output logic [XLEN-1:0] address,
    output logic [XLEN-1:0] target,
    output logic [3:0] byteenable,
    output logic misaligned,
    output execute_pkg::ecause_type ecause,
    output logic [XLEN-1:0] etval
);
    import execute_pkg::*;

    logic [XLEN-1:0] base;
    logic [XLEN-1:0] sum;
    logic is_jump;

    always_comb begin
        is_jump = address_in.jal | address_in.jalr | address_in.branch;
        base = (address_in.jal | address_in.auipc | address_in.branch) ? address_in.pc
                                                                        : address_in.rdata1;
        sum = base + address_in.imm;
        address = address_in.jalr ? {sum[XLEN-1:1], 1'b0} : sum;
        target = is_jump ? address : address_in.npc; // Fall-through when nothing jumps.

        byteenable = 4'b0000;
        misaligned = 1'b0;
        if (address_in.load | address_in.store) begin
            case (address_in.lsu_op)
                lsu_b, lsu_bu: byteenable = 4'b0001 << address[1:0];
                lsu_h, lsu_hu: begin
                    byteenable = 4'b0011 << {address[1], 1'b0};
                    misaligned = address[0];
                end
                default: begin
                    byteenable = 4'b1111;
                    misaligned = (address[1:0] != 2'b00);
                end
            endcase
        end else if (is_jump) begin
            misaligned = (address[1:0] != 2'b00);
        end

        ecause = address_in.load ? misaligned_load :
                 address_in.store ? misaligned_store : misaligned_fetch;
        etval = address;
    end

endmodule

/* hdl/branch_unit.sv */
module branch_unit #(
    parameter int XLEN = execute_pkg::xlen
) (
    input execute_pkg::bcu_op_type bcu_op,
    input logic [XLEN-1:0] rdata1,
    input logic [XLEN-1:0] rdata2,
    input logic enable,
    output logic taken
);
    import execute_pkg::*;

    logic hit;

    always_comb begin
        case (bcu_op)
            bcu_beq: hit = (rdata1 == rdata2);
            bcu_bne: hit = (rdata1 != rdata2);
            bcu_blt: hit = ($signed(rdata1) < $signed(rdata2));
            bcu_bge: hit = ($signed(rdata1) >= $signed(rdata2));
            bcu_bltu: hit = (rdata1 < rdata2);
            bcu_bgeu: hit = (rdata1 >= rdata2);
            default: hit = 1'b0;
        endcase
        taken = enable & hit;
    end

endmodule

/* hdl/alu.sv */
module alu #(
    parameter int XLEN = execute_pkg::xlen
) (
    input execute_pkg::alu_op_type alu_op,
    input logic [XLEN-1:0] alu_a,
    input logic [XLEN-1:0] alu_b,
    output logic [XLEN-1:0] alu_result
);
    import execute_pkg::*;

    logic [4:0] shamt;

    always_comb begin
        shamt = alu_b[4:0]; // Only the low five bits count for RV32 shifts.
        case (alu_op)
            alu_add:
                alu_result = alu_a + alu_b;
            alu_sub:
                alu_result = alu_a - alu_b;
            alu_sll:
                alu_result = alu_a << shamt;
            alu_slt:
                alu_result = XLEN'($signed(alu_a) < $signed(alu_b));
            alu_sltu:
                alu_result = XLEN'(alu_a < alu_b);
            alu_xor:
                alu_result = alu_a ^ alu_b;
            alu_srl:
                alu_result = alu_a >> shamt;
            alu_sra:
                alu_result = $unsigned($signed(alu_a) >>> shamt);
            alu_or:
                alu_result = alu_a | alu_b;
            alu_and:
                alu_result = alu_a & alu_b;
            default:
                alu_result = '0;
        endcase
    end

endmodule

/* hdl/execute_pkg.sv */
package execute_pkg;

    localparam int xlen = 32;

    typedef enum logic [3:0] {
        alu_add, alu_sub, alu_sll, alu_slt, alu_sltu,
        alu_xor, alu_srl, alu_sra, alu_or, alu_and
    } alu_op_type;

    // Values follow the funct3 field of the branch instructions.
    typedef enum logic [2:0] {
        bcu_beq = 3'd0, bcu_bne = 3'd1, bcu_blt = 3'd4,
        bcu_bge = 3'd5, bcu_bltu = 3'd6, bcu_bgeu = 3'd7
    } bcu_op_type;

    typedef enum logic [2:0] {
        lsu_b = 3'd0, lsu_h = 3'd1, lsu_w = 3'd2,
        lsu_bu = 3'd4, lsu_hu = 3'd5, lsu_wu = 3'd6 // Bit 2 marks zero extension.
    } lsu_op_type;

    typedef enum logic [1:0] {div_div, div_divu, div_rem, div_remu} div_op_type;

    typedef enum logic [3:0] {
        misaligned_fetch = 4'd0, misaligned_load = 4'd4, misaligned_store = 4'd6
    } ecause_type;

    typedef struct packed {
        logic valid;
        logic [xlen-1:0] pc;
        logic [xlen-1:0] npc;
        logic [xlen-1:0] imm;
        logic [xlen-1:0] rdata1;
        logic [xlen-1:0] rdata2;
        logic [4:0] waddr;
        logic wren;
        logic rden2;
        logic lui;
        logic auipc;
        logic jal;
        logic jalr;
        logic branch;
        logic load;
        logic store;
        logic division;
        alu_op_type alu_op;
        bcu_op_type bcu_op;
        lsu_op_type lsu_op;
        div_op_type div_op;
    } execute_in_type;

    typedef struct packed {
        logic valid;
        logic [xlen-1:0] pc;
        logic wren;
        logic [4:0] waddr;
        logic [xlen-1:0] wdata;
        logic load;
        logic store;
        lsu_op_type lsu_op;
        logic [xlen-1:0] address;
        logic [3:0] byteenable;
        logic [xlen-1:0] sdata;
        logic jump;
        logic [xlen-1:0] target;
        logic exception;
        ecause_type ecause;
        logic [xlen-1:0] etval;
    } execute_out_type;

    localparam execute_out_type init_execute_out = '0;

endpackage
